//--- Bender.yml
package:
  name: pb_top

sources:
  - include_dirs:
      - .
    files:
      - pb_seg_pkg.sv
      - pb_mem_pkg.sv
      - pb_bank_mem.sv
      - pb_ctrl.sv
      - pb_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pb_top.sv

//--- filelist.f
+incdir+.
pb_seg_pkg.sv
pb_mem_pkg.sv
pb_bank_mem.sv
pb_ctrl.sv
pb_top.sv
tb_pb_top.sv

//--- pb_bank_mem.sv
// single-port bank memory shell
// 16 x 40 bit array, registered read data with a one-cycle read valid

`default_nettype none

`include "pb_macros.svh"

module pb_bank_mem (
  input  logic                        i_cclk,
  input  logic                        rst,
  input  pb_mem_pkg::pb_shell_ctrl_t  i_ctrl,
  output pb_mem_pkg::pb_shell_rdata_t o_rdata
);
  import pb_mem_pkg::*;

  localparam int DEPTH = 1 << `PB_BANK_ADRS;

  logic [`PB_WORD_W-1:0] mem [DEPTH];  // raw words only
  pb_word_u              rd_word_q;    // read data register
  logic                  rd_valid_q;

  // array access, one port shared by read and write
  always_ff @(posedge i_cclk) begin
    if (i_ctrl.wr_en) begin
      mem[i_ctrl.adr] <= i_ctrl.wr_data.raw;
    end
    if (i_ctrl.rd_en) begin
      rd_word_q.raw <= mem[i_ctrl.adr];  // holds until the next read
    end
  end

  always_ff @(posedge i_cclk) begin
    if (rst) rd_valid_q <= 1'b0;
    else     rd_valid_q <= i_ctrl.rd_en;  // pulse per read
  end

  assign o_rdata.rd_valid = rd_valid_q;
  assign o_rdata.rd_data  = rd_word_q;

  // the controller keeps each bank single-ported
  a_single_port : assert property (@(posedge i_cclk) disable iff (rst)
    !(i_ctrl.rd_en && i_ctrl.wr_en))
    else $error("bank read and write in the same cycle");

endmodule

`default_nettype wire

//--- pb_ctrl.sv
// packet buffer controller
// round-robin bank striping, per-bank address pointers
// shared occupancy count with full/empty/drop
// shell command retiming and read data merge to the shim

`default_nettype none

`include "pb_macros.svh"

module pb_ctrl (
  input  logic                                         i_cclk,
  input  logic                                         rst,
  input  pb_seg_pkg::pb_rate_e                         i_port_rate,
  input  pb_seg_pkg::pb_seg_t                          i_seg,
  input  logic                                         i_rd,         // scheduler pull
  input  pb_mem_pkg::pb_shell_rdata_t [`PB_BANKS-1:0]  i_shell_rdata,
  output pb_mem_pkg::pb_shell_ctrl_t  [`PB_BANKS-1:0]  o_shell_ctrl,
  output pb_seg_pkg::pb_seg_t                          o_seg,
  output logic                                         o_full,
  output logic                                         o_empty,
  output logic                                         o_drop,
  output logic [`PB_CNT_W-1:0]                         o_used
);
  import pb_seg_pkg::*;
  import pb_mem_pkg::*;

  localparam logic [`PB_CNT_W-1:0] DPTH_1 = `PB_DPTH_1;
  localparam logic [`PB_CNT_W-1:0] DPTH_2 = `PB_DPTH_2;
  localparam logic [`PB_CNT_W-1:0] DPTH_4 = `PB_DPTH_4;

  pb_rate_e                 q_rate;
  logic [`PB_CNT_W-1:0]     depth;
  logic                     port_on;
  logic [`PB_CNT_W-1:0]     used_cnt;
  logic                     full, empty;
  logic                     wr_acc, rd_acc;
  logic [`PB_BANKS-1:0]     w_bnk, r_bnk;          // one-hot rotors
  logic [`PB_BANK_ADRS-1:0] w_adr [`PB_BANKS];
  logic [`PB_BANK_ADRS-1:0] r_adr [`PB_BANKS];
  logic [`PB_BANKS-1:0]     we_c, re_c;
  logic [`PB_BANK_ADRS-1:0] adr_c [`PB_BANKS];
  pb_word_u                 wr_word;
  logic                     drop_q, drop_qq;
  // stage 1, accepted operation per bank
  logic [`PB_BANKS-1:0]     q_we, q_re;
  logic [`PB_BANK_ADRS-1:0] q_adr [`PB_BANKS];
  pb_word_u                 q_wdata;               // one write per cycle at most
  // stage 2, shell command register
  logic [`PB_BANKS-1:0]     sh_we, sh_re;
  logic [`PB_BANK_ADRS-1:0] sh_adr [`PB_BANKS];
  pb_word_u                 sh_wdata;
  // read return path
  logic [`PB_BANKS-1:0]     rv_q;
  pb_word_u                 rd_q [`PB_BANKS];
  pb_word_u                 merge_word;
  logic                     seg_v_q;
  pb_word_u                 seg_word_q;

  // --------------------------------------------------
  // rate and depth
  // --------------------------------------------------
  always_ff @(posedge i_cclk) begin
    if (rst) q_rate <= RATE_OFF;
    else     q_rate <= i_port_rate;  // static, only retimed
  end

  always_comb begin
    unique case (q_rate)
      RATE_100G: depth = DPTH_1;
      RATE_200G: depth = DPTH_2;
      default:   depth = DPTH_4;     // off keeps max so count <= depth holds
    endcase
  end

  assign port_on = (q_rate != RATE_OFF);
  assign full    = (used_cnt == depth);
  assign empty   = (used_cnt == '0);

  // --------------------------------------------------
  // acceptance
  // --------------------------------------------------
  assign wr_acc = i_seg.valid & port_on & ~full;
  // same bank as an accepted write would need two ports
  assign rd_acc = i_rd & port_on & ~empty & ~(wr_acc & (r_bnk == w_bnk));

  always_comb begin
    for (int b = 0; b < `PB_BANKS; b++) begin
      we_c[b]  = wr_acc & w_bnk[b];
      re_c[b]  = rd_acc & r_bnk[b];
      adr_c[b] = we_c[b] ? w_adr[b] : r_adr[b];
    end
  end

  always_comb begin
    wr_word.f.tsmd = i_seg.tsmd;  // pack through the field view
    wr_word.f.d    = i_seg.d;
  end

  // rotors, address pointers and occupancy
  always_ff @(posedge i_cclk) begin
    if (rst) begin
      w_bnk    <= 'b1;
      r_bnk    <= 'b1;
      used_cnt <= '0;
      for (int b = 0; b < `PB_BANKS; b++) begin
        w_adr[b] <= '0;
        r_adr[b] <= '0;
      end
    end else begin
      if (wr_acc) w_bnk <= {w_bnk[`PB_BANKS-2:0], w_bnk[`PB_BANKS-1]};
      if (rd_acc) r_bnk <= {r_bnk[`PB_BANKS-2:0], r_bnk[`PB_BANKS-1]};
      if (wr_acc && !rd_acc)      used_cnt <= used_cnt + 1'b1;
      else if (rd_acc && !wr_acc) used_cnt <= used_cnt - 1'b1;
      for (int b = 0; b < `PB_BANKS; b++) begin
        if (we_c[b]) w_adr[b] <= w_adr[b] + 1'b1;  // wraps at 16
        if (re_c[b]) r_adr[b] <= r_adr[b] + 1'b1;
      end
    end
  end

  // drop pulse, two edges behind the refused segment
  always_ff @(posedge i_cclk) begin
    if (rst) begin
      drop_q  <= 1'b0;
      drop_qq <= 1'b0;
    end else begin
      drop_q  <= i_seg.valid & ~wr_acc;
      drop_qq <= drop_q;
    end
  end

  // --------------------------------------------------
  // shell command pipeline
  // --------------------------------------------------
  always_ff @(posedge i_cclk) begin
    if (rst) begin
      q_we  <= '0;
      q_re  <= '0;
      sh_we <= '0;
      sh_re <= '0;
    end else begin
      q_we  <= we_c;
      q_re  <= re_c;
      sh_we <= q_we;
      sh_re <= q_re;
    end
  end

  always_ff @(posedge i_cclk) begin
    q_adr    <= adr_c;
    sh_adr   <= q_adr;
    if (wr_acc) q_wdata <= wr_word;
    sh_wdata <= q_wdata;  // only sampled by the bank with wr_en
  end

  always_comb begin
    for (int b = 0; b < `PB_BANKS; b++) begin
      o_shell_ctrl[b].rd_en   = sh_re[b];
      o_shell_ctrl[b].wr_en   = sh_we[b];
      o_shell_ctrl[b].adr     = sh_adr[b];
      o_shell_ctrl[b].wr_data = sh_wdata;
    end
  end

  // --------------------------------------------------
  // read return, input stage then output stage
  // --------------------------------------------------
  always_ff @(posedge i_cclk) begin
    if (rst) rv_q <= '0;
    else for (int b = 0; b < `PB_BANKS; b++) rv_q[b] <= i_shell_rdata[b].rd_valid;
  end

  always_ff @(posedge i_cclk) begin
    for (int b = 0; b < `PB_BANKS; b++) begin
      rd_q[b] <= i_shell_rdata[b].rd_data;
    end
  end

  always_comb begin
    merge_word.raw = '0;
    for (int b = 0; b < `PB_BANKS; b++) begin
      if (rv_q[b]) merge_word.raw = merge_word.raw | rd_q[b].raw;  // at most one valid
    end
  end

  always_ff @(posedge i_cclk) begin
    if (rst) seg_v_q <= 1'b0;
    else     seg_v_q <= |rv_q;
  end

  always_ff @(posedge i_cclk) begin
    if (|rv_q) seg_word_q <= merge_word;
  end

  assign o_seg.valid = seg_v_q;
  assign o_seg.tsmd  = seg_word_q.f.tsmd;  // unpack
  assign o_seg.d     = seg_word_q.f.d;
  assign o_full      = full;
  assign o_empty     = empty;
  assign o_drop      = drop_qq;
  assign o_used      = used_cnt;

  // --------------------------------------------------
  // checks
  // --------------------------------------------------
  a_cnt_le_depth : assert property (@(posedge i_cclk) disable iff (rst)
    used_cnt <= depth)
    else $error("occupancy above selected depth");

  a_no_bank_rw : assert property (@(posedge i_cclk) disable iff (rst)
    (q_we & q_re) == '0)
    else $error("bank read and written in one cycle");

endmodule

`default_nettype wire

//--- pb_macros.svh
// packet buffer sizing constants
// bank count and per-bank address width
// metadata and data field widths
// usable depth for each port rate and occupancy count width

`ifndef PB_MACROS_SVH
`define PB_MACROS_SVH

// bank striping
`define PB_BANKS      4  // banks in the rotation
`define PB_BANK_ADRS  4  // 16 entries per bank

// segment fields
`define PB_TSMD_W     8   // timestamp/metadata
`define PB_D_W        32  // payload word
`define PB_WORD_W     (`PB_TSMD_W + `PB_D_W)

// usable depth per rate code
`define PB_DPTH_1     16  // 01
`define PB_DPTH_2     32  // 10
`define PB_DPTH_4     64  // 11, all four banks full
`define PB_CNT_W      7   // holds 0..64

`endif

//--- pb_mem_pkg.sv
// memory side types of the packet buffer
// bank word union, per-bank command and read return

`default_nettype none

`include "pb_macros.svh"

package pb_mem_pkg;

  // field view of a stored word
  typedef struct packed {
    logic [`PB_TSMD_W-1:0] tsmd;
    logic [`PB_D_W-1:0]    d;
  } pb_word_t;

  // the bank only sees raw bits, the controller packs/unpacks fields
  typedef union packed {
    logic [`PB_WORD_W-1:0] raw;
    pb_word_t              f;
  } pb_word_u;

  // --------------------------------------------------
  // controller to bank shell, one per bank
  // --------------------------------------------------
  typedef struct packed {
    logic                     rd_en;
    logic                     wr_en;    // never together with rd_en
    logic [`PB_BANK_ADRS-1:0] adr;
    pb_word_u                 wr_data;
  } pb_shell_ctrl_t;

  // bank shell to controller
  typedef struct packed {
    logic     rd_valid;  // one cycle per read
    pb_word_u rd_data;
  } pb_shell_rdata_t;

endpackage

`default_nettype wire

//--- pb_seg_pkg.sv
// segment side types of the packet buffer
// parser/shim segment struct and the port rate code

`default_nettype none

`include "pb_macros.svh"

package pb_seg_pkg;

  // --------------------------------------------------
  // one segment as seen by the parser and the shim
  // --------------------------------------------------
  typedef struct packed {
    logic                  valid;  // segment present this cycle
    logic [`PB_TSMD_W-1:0] tsmd;   // timestamp/metadata
    logic [`PB_D_W-1:0]    d;      // data word
  } pb_seg_t;

  // static port rate, sets the usable depth
  typedef enum logic [1:0] {
    RATE_OFF  = 2'b00,  // port disabled
    RATE_100G = 2'b01,  // 16 segments
    RATE_200G = 2'b10,  // 32 segments
    RATE_400G = 2'b11   // 64 segments
  } pb_rate_e;

endpackage

`default_nettype wire

//--- pb_top.sv
// packet buffer top level
// one controller driving four single-port bank shells

`default_nettype none

`include "pb_macros.svh"

module pb_top (
  input  logic                        i_cclk,
  input  logic                        rst,
  input  pb_seg_pkg::pb_rate_e        i_port_rate,
  input  pb_seg_pkg::pb_seg_t         i_seg,        // from the parser
  input  logic                        i_rd,         // from the scheduler
  output pb_seg_pkg::pb_seg_t         o_seg,        // to the shim
  output logic                        o_full,
  output logic                        o_empty,
  output logic [`PB_CNT_W-1:0]        o_used,
  output logic                        o_drop
);
  import pb_mem_pkg::*;

  pb_shell_ctrl_t  [`PB_BANKS-1:0] shell_ctrl;   // per-bank command
  pb_shell_rdata_t [`PB_BANKS-1:0] shell_rdata;  // per-bank read return

  pb_ctrl i_pb_ctrl (
    .i_cclk        (i_cclk),
    .rst           (rst),
    .i_port_rate   (i_port_rate),
    .i_seg         (i_seg),
    .i_rd          (i_rd),
    .i_shell_rdata (shell_rdata),
    .o_shell_ctrl  (shell_ctrl),
    .o_seg         (o_seg),
    .o_full        (o_full),
    .o_empty       (o_empty),
    .o_drop        (o_drop),
    .o_used        (o_used)
  );

  // one shell per bank in the rotation
  for (genvar g = 0; g < `PB_BANKS; g++) begin : g_bank
    pb_bank_mem i_pb_bank_mem (
      .i_cclk  (i_cclk),
      .rst     (rst),
      .i_ctrl  (shell_ctrl[g]),
      .o_rdata (shell_rdata[g])
    );
  end

endmodule

`default_nettype wire

//--- tb_pb_top.sv
// testbench for the packet buffer top level
// table of traffic phases applied in a loop, reference queue model
// checks output order, occupancy, full/empty and drop timing

`default_nettype none

`include "pb_macros.svh"

module tb_pb_top;
  import pb_seg_pkg::*;

  // one traffic phase, odds are in quarters (4 = every cycle)
  typedef struct packed {
    pb_rate_e             rate;
    logic [15:0]          cycles;
    logic [2:0]           wr_q;
    logic [2:0]           rd_q;
    logic                 chk_lvl;  // check fill level after the traffic
    logic [`PB_CNT_W-1:0] lvl;
    logic                 full;
  } row_t;

  localparam int NROWS = 7;
  localparam row_t ROWS [NROWS] = '{
    '{RATE_400G, 16'd8,   3'd4, 3'd0, 1'b1, 7'd8,  1'b0},  // in-order striping
    '{RATE_100G, 16'd20,  3'd4, 3'd0, 1'b1, 7'd16, 1'b1},  // depth per rate
    '{RATE_200G, 16'd36,  3'd4, 3'd0, 1'b1, 7'd32, 1'b1},
    '{RATE_400G, 16'd68,  3'd4, 3'd0, 1'b1, 7'd64, 1'b1},
    '{RATE_OFF,  16'd10,  3'd4, 3'd4, 1'b1, 7'd0,  1'b0},  // port off
    '{RATE_400G, 16'd10,  3'd0, 3'd4, 1'b1, 7'd0,  1'b0},  // reads while empty
    '{RATE_400G, 16'd300, 3'd3, 3'd3, 1'b0, 7'd0,  1'b0}   // random traffic
  };
  string names [NROWS] = '{"in_order", "depth_16", "depth_32", "depth_64",
                           "port_off", "rd_empty", "random"};

  logic                 i_cclk, rst, i_rd;
  pb_rate_e             i_port_rate;
  pb_seg_t              i_seg, o_seg;
  logic                 o_full, o_empty, o_drop;
  logic [`PB_CNT_W-1:0] o_used;

  // reference model
  logic [`PB_WORD_W-1:0] mq [$];        // accepted words, oldest first
  logic [`PB_WORD_W-1:0] exp_word [$];  // words on their way to o_seg
  int       exp_edge [$];               // edge after which each word shows
  int       drop_edge [$];
  int       m_used = 0;
  int       m_wb = 0;                   // next write bank
  int       m_rb = 0;                   // next read bank
  int       edge_n = 0;
  int       seq = 1;                    // running segment number
  pb_rate_e m_rate = RATE_OFF;          // rate as the DUT has registered it
  logic [31:0] rng = 32'h07e2_202d;
  int       errors = 0;
  int       checks = 0;
  int       e0;

  pb_top i_pb_top (
    .i_cclk (i_cclk), .rst (rst), .i_port_rate (i_port_rate), .i_seg (i_seg),
    .i_rd (i_rd), .o_seg (o_seg), .o_full (o_full), .o_empty (o_empty),
    .o_used (o_used), .o_drop (o_drop)
  );

  initial begin
    i_cclk = 1'b0;
    forever #5 i_cclk = ~i_cclk;
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic draw(input logic [2:0] q);
    rng = xorshift(rng);
    return {1'b0, rng[17:16]} < q;  // true with odds q/4
  endfunction

  function automatic int depth_of(input pb_rate_e r);
    case (r)
      RATE_100G: return `PB_DPTH_1;
      RATE_200G: return `PB_DPTH_2;
      RATE_400G: return `PB_DPTH_4;
      default:   return 0;             // port off holds nothing
    endcase
  endfunction

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  // outputs as they stand one unit after edge edge_n
  task automatic compare();
    logic                  xv, xd;
    logic [`PB_WORD_W-1:0] xw;
    xv = exp_edge.size() > 0 && exp_edge[0] == edge_n;
    check(64'(o_seg.valid), 64'(xv), "o_seg.valid");
    if (xv) begin
      xw = exp_word.pop_front();
      void'(exp_edge.pop_front());
      check(64'({o_seg.tsmd, o_seg.d}), 64'(xw), "o_seg word");
    end
    xd = drop_edge.size() > 0 && drop_edge[0] == edge_n;
    if (xd) void'(drop_edge.pop_front());
    check(64'(o_drop), 64'(xd), "o_drop");
    check(64'(o_used), 64'(m_used), "o_used");
    check(64'(o_empty), 64'(m_used == 0), "o_empty");
    check(64'(o_full), 64'(m_rate != RATE_OFF && m_used == depth_of(m_rate)), "o_full");
  endtask

  // drive one cycle, step the model across the edge, then compare
  task automatic tick(input logic v, input logic rd);
    logic [`PB_WORD_W-1:0] w;
    logic                  wa, ra;
    w  = {seq[`PB_TSMD_W-1:0], xorshift(seq)};
    wa = v && m_rate != RATE_OFF && m_used < depth_of(m_rate);
    ra = rd && m_rate != RATE_OFF && m_used > 0 && !(wa && m_rb == m_wb);  // one port per bank
    i_seg.valid = v;
    i_seg.tsmd  = w[`PB_WORD_W-1:`PB_D_W];
    i_seg.d     = w[`PB_D_W-1:0];
    i_rd        = rd;
    @(posedge i_cclk);
    edge_n++;
    if (v) seq++;
    if (wa) begin
      mq.push_back(w);
      m_wb = (m_wb + 1) % `PB_BANKS;
      m_used++;
    end
    if (ra) begin
      exp_word.push_back(mq.pop_front());
      exp_edge.push_back(edge_n + 4);   // bank, two return stages, output
      m_rb = (m_rb + 1) % `PB_BANKS;
      m_used--;
    end
    if (v && !wa) drop_edge.push_back(edge_n + 1);
    m_rate = i_port_rate;
    #1;
    compare();
  endtask

  task automatic run_row(input int r);
    logic v, rd;
    int   n;
    e0 = errors;
    i_port_rate = ROWS[r].rate;
    tick(1'b0, 1'b0);  // let the rate register settle
    for (int c = 0; c < ROWS[r].cycles; c++) begin
      v  = draw(ROWS[r].wr_q);
      rd = draw(ROWS[r].rd_q);
      tick(v, rd);
    end
    if (ROWS[r].chk_lvl) begin
      check(64'(o_used), 64'(ROWS[r].lvl), "fill level");
      check(64'(o_full), 64'(ROWS[r].full), "o_full after fill");
    end
    // drain with reads until the DUT reports empty
    n = 0;
    while (!o_empty && n < 200) begin
      tick(1'b0, 1'b1);
      n++;
    end
    if (!o_empty) begin
      $display("timeout: %s did not drain to empty within 200 cycles", names[r]);
      errors++;
    end
    // wait for the reads in flight to reach o_seg
    n = 0;
    while ((exp_edge.size() > 0 || drop_edge.size() > 0) && n < 8) begin
      tick(1'b0, 1'b0);
      n++;
    end
    if (exp_edge.size() > 0 || drop_edge.size() > 0) begin
      $display("timeout: %s read pipeline still busy after 8 cycles", names[r]);
      errors++;
    end
    $display("%-9s %0d cycles, %0d errors", names[r], ROWS[r].cycles, errors - e0);
  endtask

  // --------------------------------------------------
  // sequence
  // --------------------------------------------------
  initial begin
    rst         = 1'b1;
    i_rd        = 1'b0;
    i_seg       = '0;
    i_port_rate = RATE_OFF;
    repeat (2) @(posedge i_cclk);
    #1;
    rst = 1'b0;
    e0  = errors;
    check(64'(o_empty), 64'd1, "o_empty after reset");
    check(64'(o_full), 64'd0, "o_full after reset");
    check(64'(o_used), 64'd0, "o_used after reset");
    check(64'(o_seg.valid), 64'd0, "o_seg.valid after reset");
    check(64'(o_drop), 64'd0, "o_drop after reset");
    $display("%-9s %0d errors", "reset", errors - e0);
    for (int r = 0; r < NROWS; r++) begin
      run_row(r);
    end
    $display("%0d tests, %0d checks, %0d errors", NROWS + 1, checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  // global cycle cap
  initial begin
    repeat (5000) @(posedge i_cclk);
    $display("simulation stopped, cycle limit reached");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire
